// ==== verification/core_stimulus.txt ====
# columns: P word_index instruction | S byte_address data | C store_count (hex except C)
# program, addresses 0x000 .. 0x0f4
P 00 00500093
P 01 FFD00113
P 02 002081B3
P 03 10302023
P 04 40208233
P 05 002242B3
P 06 10402223
P 07 10502423
P 08 00126333
P 09 0062F3B3
P 0A 10602623
P 0B 10702823
P 0C 00409413
P 0D 40115493
P 0E 00115533
P 0F 10802A23
P 10 10902C23
P 11 10A02E23
P 12 001125B3
P 13 00113633
P 14 12B02023
P 15 12C02223
P 16 123456B7
P 17 00001717
P 18 12D02423
P 19 12E02623
P 1A 00108663
P 1B 1E102823
P 1C 1E102823
P 1D 00109463
P 1E 12202823
P 1F 00114663
P 20 1E102823
P 21 1E102823
P 22 00115463
P 23 12102A23
P 24 0020D663
P 25 1E102823
P 26 1E102823
P 27 00208463
P 28 0020C463
P 29 00209663
P 2A 1E102823
P 2B 1E102823
P 2C 00C007EF
P 2D 1E102823
P 2E 1E102823
P 2F 12F02C23
P 30 0D400813
P 31 000808E7
P 32 1E102823
P 33 1E102823
P 34 1E102823
P 35 13102E23
P 36 14D02023
P 37 14002903
P 38 00190993
P 39 15302223
P 3A 15202423
P 3B 00100073
P 3C 1E102823
P 3D 00000013
# expected stores in order
S 00000100 00000002
S 00000104 00000008
S 00000108 FFFFFFF5
S 0000010C 0000000D
S 00000110 00000005
S 00000114 00000050
S 00000118 FFFFFFFE
S 0000011C 07FFFFFF
S 00000120 00000001
S 00000124 00000000
S 00000128 12345000
S 0000012C 0000105C
S 00000130 FFFFFFFD
S 00000134 00000005
S 00000138 000000B4
S 0000013C 000000C8
S 00000140 12345000
S 00000144 12345001
S 00000148 12345000
# total number of stores
C 19

// ==== tb.f ====
rtl/rv_core_pkg.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_writeback.sv
rtl/hazard_unit.sv
rtl/riscv_core.sv
verification/tb_clock_gen.sv
verification/tb_riscv_core.sv

// ==== Makefile ====
# Verilator build and run of the rv32i core testbench

VERILATOR ?= verilator
TOP       ?= tb_riscv_core
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= -sv --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/tb_riscv_core.sv ====
// ==================================================
// testbench of the rv32i core: loads the program from the
// stimulus file, checks every store in order and the halt
// ==================================================
`default_nettype none

module tb_riscv_core;
    import rv_core_pkg::*;

    localparam string STIM_FILE     = "verification/core_stimulus.txt";
    localparam int    RESET_TIMEOUT = 100;   // cycles
    localparam int    HALT_TIMEOUT  = 5000;
    localparam int    QUIET_CYCLES  = 8;     // watch window after halt

    logic       clk;
    logic       rst_n;
    logic       hold_reset;
    imem_wr_t   imem_wr;
    store_obs_t store_obs;
    logic       halt;

    xlen_t  prog_addr [$];   // word index
    instr_t prog_word [$];
    xlen_t  exp_addr  [$];   // expected stores, in order
    xlen_t  exp_data  [$];
    int     exp_count;
    int     stores_seen;

    tb_clock_gen #(.HALF_PERIOD(5), .RESET_CYCLES(10)) u_clock_gen (
        .hold_reset (hold_reset),
        .clk        (clk),
        .rst_n      (rst_n)
    );

    riscv_core #(.IMEM_DEPTH(256), .DMEM_DEPTH(256)) u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_wr   (imem_wr),
        .store_obs (store_obs),
        .halt      (halt)
    );

    // ==============================================
    // failure and compare helpers
    // ==============================================
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_store(input store_obs_t got);
        if (stores_seen >= exp_addr.size()) begin
            fail_run($sformatf("unexpected extra store of %h to address %h at time %0t",
                               got.data, got.addr, $time));
        end else if ((got.addr !== exp_addr[stores_seen]) ||
                     (got.data !== exp_data[stores_seen])) begin
            fail_run($sformatf("mismatch at %0t: store %0d wrote %h to %h, expected %h to %h",
                               $time, stores_seen, got.data, got.addr,
                               exp_data[stores_seen], exp_addr[stores_seen]));
        end else begin
            stores_seen++;
        end
    endtask

    task automatic compare_count(input int got, input int expected);
        if (got != expected) begin
            fail_run($sformatf("mismatch at %0t: %0d stores seen, expected %0d",
                               $time, got, expected));
        end
    endtask

    // ==============================================
    // stimulus file, tagged lines P / S / C, # starts a comment
    // ==============================================
    task automatic read_stimulus();
        int    fd;
        int    code;
        int    n;
        logic  done;
        string tag;
        string rest;
        xlen_t a;
        xlen_t d;
        fd   = $fopen(STIM_FILE, "r");
        done = 1'b0;
        if (fd == 0) begin
            fail_run({"could not open the stimulus file ", STIM_FILE});
        end else begin
            while (!done) begin
                code = $fscanf(fd, "%s", tag);
                if (code != 1) begin
                    done = 1'b1;                    // end of file
                end else if (tag == "#") begin
                    code = $fgets(rest, fd);        // skip comment text
                end else if (tag == "P" || tag == "S") begin
                    code = $fscanf(fd, "%h %h", a, d);
                    if (code != 2) begin
                        fail_run({"malformed line with tag ", tag, " in the stimulus file"});
                    end else if (tag == "P") begin
                        prog_addr.push_back(a);
                        prog_word.push_back(d);
                    end else begin
                        exp_addr.push_back(a);
                        exp_data.push_back(d);
                    end
                end else if (tag == "C") begin
                    code = $fscanf(fd, "%d", n);
                    exp_count = n;
                end else begin
                    fail_run({"unknown tag ", tag, " in the stimulus file"});
                end
            end
            $fclose(fd);
        end
    endtask

    // store monitor, sampled mid-cycle where the mem stage is stable
    always @(negedge clk) begin
        if (rst_n && store_obs.valid) begin
            compare_store(store_obs);
        end
    end

    // ==============================================
    // main sequence
    // ==============================================
    initial begin
        int cycles;
        hold_reset  = 1'b1;
        imem_wr     = '0;
        exp_count   = 0;
        stores_seen = 0;
        read_stimulus();

        // program load, one word per rising edge while reset is held
        for (int i = 0; i < prog_addr.size(); i++) begin
            @(posedge clk);
            imem_wr <= '{valid: 1'b1, addr: prog_addr[i], data: prog_word[i]};
        end
        @(posedge clk);
        imem_wr    <= '0;
        hold_reset <= 1'b0;

        cycles = 0;
        while (!rst_n && (cycles < RESET_TIMEOUT)) begin
            @(posedge clk);
            cycles++;
        end
        if (!rst_n) begin
            fail_run("timed out waiting for reset to be released after program load");
        end else begin
            cycles = 0;
            while (!halt && (cycles < HALT_TIMEOUT)) begin
                @(posedge clk);
                cycles++;
            end
            if (!halt) begin
                fail_run("timed out waiting for the core to halt on EBREAK");
            end else begin
                repeat (QUIET_CYCLES) @(negedge clk);   // nothing may store after halt
                compare_count(stores_seen, exp_count);
                if (halt) begin
                    $display("NO ERRORS");
                    $finish;
                end else begin
                    fail_run("halt dropped after it had been raised");
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
// ==================================================
// testbench clock and reset source, period 10
// reset stays low while hold_reset is set, then 10 more cycles
// ==================================================
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 10
) (
    input  logic hold_reset,   // high while the program is loaded
    output logic clk,
    output logic rst_n
);

    int low_cycles;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release on a falling edge, away from the dut sampling edge
    initial begin
        rst_n      = 1'b0;
        low_cycles = 0;
        while (low_cycles < RESET_CYCLES) begin
            @(negedge clk);
            if (hold_reset) begin
                low_cycles = 0;      // count restarts until loading is over
            end else begin
                low_cycles++;
            end
        end
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== rtl/riscv_core.sv ====
// ==================================================
// five-stage rv32i core top, stages plus hazard unit
// ==================================================
`default_nettype none

module riscv_core #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rv_core_pkg::imem_wr_t   imem_wr,
    output rv_core_pkg::store_obs_t store_obs,
    output logic                    halt
);
    import rv_core_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;
    xlen_t     wb_data, mem_fwd_data, redirect_pc;
    reg_addr_t rs1_d, rs2_d;
    fwd_sel_e  fwd_a, fwd_b;
    logic      redirect, flush, rf_bypass_a, rf_bypass_b;
    logic      adv_fd, adv_de, adv_em, adv_mw;

    fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) u_fetch (
        .clk(clk), .rst_n(rst_n), .imem_wr(imem_wr), .redirect(redirect),
        .redirect_pc(redirect_pc), .flush(flush), .advance(adv_fd), .if_id(if_id)
    );

    decode_stage u_decode (
        .clk(clk), .rst_n(rst_n), .if_id(if_id), .flush(flush), .advance(adv_de),
        .rf_bypass_a(rf_bypass_a), .rf_bypass_b(rf_bypass_b), .mem_wb(mem_wb),
        .wb_data(wb_data), .rs1(rs1_d), .rs2(rs2_d), .id_ex(id_ex)
    );

    execute_stage u_execute (
        .clk(clk), .rst_n(rst_n), .id_ex(id_ex), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .mem_fwd_data(mem_fwd_data), .wb_data(wb_data), .advance(adv_em),
        .redirect(redirect), .redirect_pc(redirect_pc), .ex_mem(ex_mem)
    );

    memory_writeback #(.DMEM_DEPTH(DMEM_DEPTH)) u_mem_wb (
        .clk(clk), .rst_n(rst_n), .ex_mem(ex_mem), .advance(adv_mw),
        .mem_fwd_data(mem_fwd_data), .mem_wb(mem_wb), .wb_data(wb_data),
        .store_obs(store_obs), .halt(halt)
    );

    hazard_unit u_hazard (
        .rs1_d(rs1_d), .rs2_d(rs2_d), .id_ex(id_ex), .ex_mem(ex_mem), .mem_wb(mem_wb),
        .redirect(redirect), .fwd_a(fwd_a), .fwd_b(fwd_b), .rf_bypass_a(rf_bypass_a),
        .rf_bypass_b(rf_bypass_b), .flush(flush), .adv_fd(adv_fd), .adv_de(adv_de),
        .adv_em(adv_em), .adv_mw(adv_mw)
    );

endmodule

`default_nettype wire

// ==== rtl/hazard_unit.sv ====
// ==================================================
// forwarding / bypass detection, flush and the
// stage-advance lines of the halt drain
// ==================================================
`default_nettype none

module hazard_unit (
    input  rv_core_pkg::reg_addr_t rs1_d,
    input  rv_core_pkg::reg_addr_t rs2_d,
    input  rv_core_pkg::id_ex_t    id_ex,
    input  rv_core_pkg::ex_mem_t   ex_mem,
    input  rv_core_pkg::mem_wb_t   mem_wb,
    input  logic                   redirect,
    output rv_core_pkg::fwd_sel_e  fwd_a,
    output rv_core_pkg::fwd_sel_e  fwd_b,
    output logic                   rf_bypass_a,
    output logic                   rf_bypass_b,
    output logic                   flush,
    output logic                   adv_fd,
    output logic                   adv_de,
    output logic                   adv_em,
    output logic                   adv_mw
);
    import rv_core_pkg::*;

    // producer writes a real register that the consumer reads
    function automatic logic hit(input logic wr, input reg_addr_t rd, input reg_addr_t rs);
        return wr && (rd != '0) && (rd == rs);
    endfunction

    // memory stage is younger so it wins
    assign fwd_a = hit(ex_mem.rf_wr, ex_mem.rd, id_ex.rs1) ? FWD_MEM :
                   hit(mem_wb.rf_wr, mem_wb.rd, id_ex.rs1) ? FWD_WB : FWD_NONE;
    assign fwd_b = hit(ex_mem.rf_wr, ex_mem.rd, id_ex.rs2) ? FWD_MEM :
                   hit(mem_wb.rf_wr, mem_wb.rd, id_ex.rs2) ? FWD_WB : FWD_NONE;

    assign rf_bypass_a = hit(mem_wb.rf_wr, mem_wb.rd, rs1_d);
    assign rf_bypass_b = hit(mem_wb.rf_wr, mem_wb.rd, rs2_d);

    assign flush = redirect;

    // ebreak freezes the front end, then each later register as it arrives
    assign adv_fd = !id_ex.ctrl.halt;
    assign adv_de = !id_ex.ctrl.halt;
    assign adv_em = !ex_mem.halt;
    assign adv_mw = !mem_wb.halt;

endmodule

`default_nettype wire

// ==== rtl/memory_writeback.sv ====
// ==================================================
// data memory, mem/wb register and writeback select
// ==================================================
`default_nettype none

module memory_writeback #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  rv_core_pkg::ex_mem_t    ex_mem,
    input  logic                    advance,
    output rv_core_pkg::xlen_t      mem_fwd_data,
    output rv_core_pkg::mem_wb_t    mem_wb,
    output rv_core_pkg::xlen_t      wb_data,
    output rv_core_pkg::store_obs_t store_obs,
    output logic                    halt
);
    import rv_core_pkg::*;

    localparam int AW = $clog2(DMEM_DEPTH);

    xlen_t dmem [DMEM_DEPTH];  // word ram
    xlen_t mem_data;

    // ==============================================
    // memory stage
    // ==============================================
    assign mem_data = dmem[ex_mem.alu_result[AW+1:2]];  // combinational read

    always_ff @(posedge clk) begin
        if (ex_mem.mem_wr) begin
            dmem[ex_mem.alu_result[AW+1:2]] <= ex_mem.store_data;
        end
    end

    assign store_obs = '{valid: ex_mem.mem_wr, addr: ex_mem.alu_result,
                         data: ex_mem.store_data};

    always_comb begin
        case (ex_mem.wb_sel)
            WB_MEM:  mem_fwd_data = mem_data;       // load result forwards without a stall
            WB_PC4:  mem_fwd_data = ex_mem.pc_plus_4;
            default: mem_fwd_data = ex_mem.alu_result;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wb <= '0;
        end else if (advance) begin
            mem_wb <= '{alu_result: ex_mem.alu_result, mem_data: mem_data,
                        pc_plus_4: ex_mem.pc_plus_4, rd: ex_mem.rd, wb_sel: ex_mem.wb_sel,
                        rf_wr: ex_mem.rf_wr, halt: ex_mem.halt};
        end
    end

    // ==============================================
    // writeback stage
    // ==============================================
    always_comb begin
        case (mem_wb.wb_sel)
            WB_MEM:  wb_data = mem_wb.mem_data;
            WB_PC4:  wb_data = mem_wb.pc_plus_4;
            default: wb_data = mem_wb.alu_result;
        endcase
    end

    assign halt = mem_wb.halt;  // held since mem/wb freezes on it

    // addresses come from execute and only whole words exist
    a_store_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        ex_mem.mem_wr |-> (ex_mem.alu_result[1:0] == 2'b00));

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
// ==================================================
// execute stage: forwarding, alu, branch resolution
// and the ex/mem register
// ==================================================
`default_nettype none

module execute_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_core_pkg::id_ex_t   id_ex,
    input  rv_core_pkg::fwd_sel_e fwd_a,
    input  rv_core_pkg::fwd_sel_e fwd_b,
    input  rv_core_pkg::xlen_t    mem_fwd_data,
    input  rv_core_pkg::xlen_t    wb_data,
    input  logic                  advance,
    output logic                  redirect,
    output rv_core_pkg::xlen_t    redirect_pc,
    output rv_core_pkg::ex_mem_t  ex_mem
);
    import rv_core_pkg::*;

    xlen_t rs1_fwd, rs2_fwd;   // register operands after forwarding
    xlen_t op_a, op_b, alu_result, pc_plus_4;
    logic  zero, less_than, br_taken;

    always_comb begin
        case (fwd_a)
            FWD_MEM: rs1_fwd = mem_fwd_data;
            FWD_WB:  rs1_fwd = wb_data;
            default: rs1_fwd = id_ex.rs1_data;
        endcase
        case (fwd_b)
            FWD_MEM: rs2_fwd = mem_fwd_data;
            FWD_WB:  rs2_fwd = wb_data;
            default: rs2_fwd = id_ex.rs2_data;
        endcase
    end

    assign op_a = id_ex.ctrl.a_is_pc ? id_ex.pc : rs1_fwd;
    assign op_b = id_ex.ctrl.use_imm ? id_ex.imm : rs2_fwd;

    alu u_alu (
        .op        (id_ex.ctrl.alu_op),
        .a         (op_a),
        .b         (op_b),
        .result    (alu_result),
        .zero      (zero),
        .less_than (less_than)
    );

    always_comb begin
        case (id_ex.ctrl.br_cond)
            BR_EQ:   br_taken = zero;
            BR_NE:   br_taken = !zero;
            BR_LT:   br_taken = less_than;
            BR_GE:   br_taken = !less_than;
            default: br_taken = 1'b0;
        endcase
    end

    assign redirect    = br_taken || id_ex.ctrl.jump;
    assign redirect_pc = id_ex.ctrl.jalr ? {alu_result[31:1], 1'b0}  // jalr clears bit 0
                                         : id_ex.pc + id_ex.imm;
    assign pc_plus_4   = id_ex.pc + 32'd4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (advance) begin
            ex_mem <= '{alu_result: alu_result, store_data: rs2_fwd, pc_plus_4: pc_plus_4,
                        rd: id_ex.rd, mem_wr: id_ex.ctrl.mem_wr, wb_sel: id_ex.ctrl.wb_sel,
                        rf_wr: id_ex.ctrl.rf_wr, halt: id_ex.ctrl.halt};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
// ==================================================
// decode stage: control decode, immediates, register
// read with writeback bypass and the id/ex register
// ==================================================
`default_nettype none

module decode_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv_core_pkg::if_id_t    if_id,
    input  logic                   flush,
    input  logic                   advance,
    input  logic                   rf_bypass_a,
    input  logic                   rf_bypass_b,
    input  rv_core_pkg::mem_wb_t   mem_wb,
    input  rv_core_pkg::xlen_t     wb_data,
    output rv_core_pkg::reg_addr_t rs1,
    output rv_core_pkg::reg_addr_t rs2,
    output rv_core_pkg::id_ex_t    id_ex
);
    import rv_core_pkg::*;

    instr_t    instr;
    opcode_t   opcode;
    logic [2:0] funct3;
    logic      alt;          // instr[30], sub / sra select
    reg_addr_t rd;
    xlen_t     imm_i, imm_s, imm_b, imm_u, imm_j, imm;
    xlen_t     rf_rs1, rf_rs2, rs1_data, rs2_data;
    ctrl_t     ctrl;

    function automatic alu_op_e alu_fn(input logic [2:0] f3, input logic sel_alt);
        case (f3)
            3'b000:  return sel_alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return sel_alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign instr  = if_id.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign alt    = instr[30];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl = '0;       // unknown opcodes decode to a bubble
        imm  = imm_i;
        case (opcode)
            OP_LUI: begin
                ctrl.alu_op  = ALU_PASS_B;
                ctrl.use_imm = 1'b1;
                ctrl.rf_wr   = 1'b1;
                imm          = imm_u;
            end
            OP_AUIPC, OP_JAL: begin
                ctrl.a_is_pc = 1'b1;   // pc + imm
                ctrl.use_imm = 1'b1;
                ctrl.rf_wr   = 1'b1;
                ctrl.jump    = (opcode == OP_JAL);
                ctrl.wb_sel  = (opcode == OP_JAL) ? WB_PC4 : WB_ALU;
                imm          = (opcode == OP_JAL) ? imm_j : imm_u;
            end
            OP_JALR: begin
                ctrl.use_imm = 1'b1;
                ctrl.jump    = 1'b1;
                ctrl.jalr    = 1'b1;
                ctrl.wb_sel  = WB_PC4;  // link value
                ctrl.rf_wr   = 1'b1;
            end
            OP_BRANCH: begin
                ctrl.alu_op = ALU_SUB;  // flags from rs1 - rs2
                imm         = imm_b;
                case (funct3)
                    3'b000:  ctrl.br_cond = BR_EQ;
                    3'b001:  ctrl.br_cond = BR_NE;
                    3'b100:  ctrl.br_cond = BR_LT;
                    3'b101:  ctrl.br_cond = BR_GE;
                    default: ctrl.br_cond = BR_NONE;
                endcase
            end
            OP_LOAD: begin
                ctrl.use_imm = 1'b1;
                ctrl.wb_sel  = WB_MEM;
                ctrl.rf_wr   = 1'b1;
            end
            OP_STORE: begin
                ctrl.use_imm = 1'b1;
                ctrl.mem_wr  = 1'b1;
                imm          = imm_s;
            end
            OP_IMM: begin
                ctrl.alu_op  = alu_fn(funct3, alt && (funct3 == 3'b101));  // no subi
                ctrl.use_imm = 1'b1;
                ctrl.rf_wr   = 1'b1;
            end
            OP_REG: begin
                ctrl.alu_op = alu_fn(funct3, alt);
                ctrl.rf_wr  = 1'b1;
            end
            OP_SYSTEM: ctrl.halt = (instr[31:20] == 12'h001);  // ebreak
            default: ctrl = '0;
        endcase
    end

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rf_rs1),
        .rs2_data (rf_rs2),
        .wr_en    (mem_wb.rf_wr),
        .rd       (mem_wb.rd),
        .rd_data  (wb_data)
    );

    // same-cycle writeback wins over the stale array value
    assign rs1_data = rf_bypass_a ? wb_data : rf_rs1;
    assign rs2_data = rf_bypass_b ? wb_data : rf_rs2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (flush) begin
            id_ex <= '0;    // second bubble of a redirect
        end else if (advance) begin
            id_ex <= '{ctrl: ctrl, rs1_data: rs1_data, rs2_data: rs2_data, imm: imm,
                       pc: if_id.pc, rd: rd, rs1: rs1, rs2: rs2};
        end
    end

    // execute must never see a jump that is also a conditional branch
    a_jump_xor_branch: assert property (@(posedge clk) disable iff (!rst_n)
        !(id_ex.ctrl.jump && (id_ex.ctrl.br_cond != BR_NONE)));

endmodule

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
// ==================================================
// fetch stage with pc, instruction memory + load port
// and the if/id register
// ==================================================
`default_nettype none

module fetch_stage #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_core_pkg::imem_wr_t imem_wr,
    input  logic                  redirect,
    input  rv_core_pkg::xlen_t    redirect_pc,
    input  logic                  flush,
    input  logic                  advance,
    output rv_core_pkg::if_id_t   if_id
);
    import rv_core_pkg::*;

    localparam int AW = $clog2(IMEM_DEPTH);

    instr_t imem [IMEM_DEPTH];  // program store, loaded while in reset
    xlen_t  pc;
    instr_t fetched;

    always_ff @(posedge clk) begin
        if (imem_wr.valid) begin
            imem[imem_wr.addr[AW-1:0]] <= imem_wr.data;
        end
    end

    assign fetched = flush ? NOP_INSTR : imem[pc[AW+1:2]];  // wrong-path slot becomes nop

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= '0;
            if_id <= '{instr: NOP_INSTR, pc: '0};
        end else begin
            if (redirect) begin
                pc <= redirect_pc;    // taken branch or jump from execute
            end else if (advance) begin
                pc <= pc + 32'd4;
            end
            if (advance || flush) begin
                if_id <= '{instr: fetched, pc: pc};
            end
        end
    end

    // program loading is only legal while the core sits in reset
    a_no_load_when_running: assert property (@(posedge clk) disable iff (!rst_n)
        !imem_wr.valid);

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
// ==================================================
// 32 x 32 register file, x0 reads as zero
// ==================================================
`default_nettype none

module reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv_core_pkg::reg_addr_t rs1,
    input  rv_core_pkg::reg_addr_t rs2,
    output rv_core_pkg::xlen_t     rs1_data,
    output rv_core_pkg::xlen_t     rs2_data,
    input  logic                   wr_en,
    input  rv_core_pkg::reg_addr_t rd,
    input  rv_core_pkg::xlen_t     rd_data
);
    import rv_core_pkg::*;

    xlen_t regs [1:31];  // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (rd != '0)) begin
            regs[rd] <= rd_data;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];  // asynchronous reads
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
// ==================================================
// rv32i alu with zero and less-than flags
// ==================================================
`default_nettype none

module alu (
    input  rv_core_pkg::alu_op_e op,
    input  rv_core_pkg::xlen_t   a,
    input  rv_core_pkg::xlen_t   b,
    output rv_core_pkg::xlen_t   result,
    output logic                 zero,
    output logic                 less_than
);
    import rv_core_pkg::*;

    logic lt_s, lt_u;

    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_SLL:    result = a << b[4:0];     // shamt is the low 5 bits
            ALU_SRL:    result = a >> b[4:0];
            ALU_SRA:    result = xlen_t'($signed(a) >>> b[4:0]);
            ALU_SLT:    result = {31'b0, lt_s};
            ALU_SLTU:   result = {31'b0, lt_u};
            ALU_PASS_B: result = b;               // lui
            default:    result = '0;
        endcase
    end

    assign zero      = (result == '0);                 // beq / bne after sub
    assign less_than = (op == ALU_SLTU) ? lt_u : lt_s;

endmodule

`default_nettype wire

// ==== rtl/rv_core_pkg.sv ====
// ==================================================
// shared types, opcodes and stage-register structs
// of the rv32i core, imported by every rtl module
// ==================================================
`default_nettype none

package rv_core_pkg;

    typedef logic [31:0] xlen_t;      // data or address word
    typedef logic [4:0]  reg_addr_t;  // register index
    typedef logic [31:0] instr_t;
    typedef logic [6:0]  opcode_t;

    localparam instr_t NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0

    // major opcodes of the supported subset
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_SYSTEM = 7'b1110011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B
    } alu_op_e;  // add must stay 0 so a cleared ctrl is harmless

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;
    typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE} br_cond_e;
    typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_e;

    // program load port of the instruction memory
    typedef struct packed {
        logic   valid;
        xlen_t  addr;   // word index
        instr_t data;
    } imem_wr_t;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     use_imm;  // operand b is the immediate
        logic     a_is_pc;  // operand a is the pc
        br_cond_e br_cond;
        logic     jump;
        logic     jalr;     // target from alu result
        logic     mem_wr;
        wb_sel_e  wb_sel;
        logic     rf_wr;
        logic     halt;
    } ctrl_t;

    typedef struct packed {instr_t instr; xlen_t pc;} if_id_t;

    typedef struct packed {
        ctrl_t     ctrl;
        xlen_t     rs1_data, rs2_data, imm, pc;
        reg_addr_t rd, rs1, rs2;
    } id_ex_t;

    typedef struct packed {
        xlen_t     alu_result, store_data, pc_plus_4;
        reg_addr_t rd;
        logic      mem_wr;
        wb_sel_e   wb_sel;
        logic      rf_wr, halt;
    } ex_mem_t;

    typedef struct packed {
        xlen_t     alu_result, mem_data, pc_plus_4;
        reg_addr_t rd;
        wb_sel_e   wb_sel;
        logic      rf_wr, halt;
    } mem_wb_t;

    typedef struct packed {logic valid; xlen_t addr; xlen_t data;} store_obs_t;

endpackage

`default_nettype wire
